// File: rtl/dnc_settings.svh
`ifndef DNC_SETTINGS_SVH
`define DNC_SETTINGS_SVH

// Shared sizes for the DNC output vector subsystem

// Width of one data word
// Arithmetic wraps modulo 2^DNC_DATA_WIDTH
`define DNC_DATA_WIDTH 16

// Row and column index width
// Must hold every value from 0 up to the largest size
`define DNC_INDEX_WIDTH 4

// Largest number of rows of U
// One result per row
`define DNC_MAX_Y 8

// Largest number of columns of U
// Same as the length of h
`define DNC_MAX_L 8

`endif

// File: rtl/dnc_pkg.sv
`include "dnc_settings.svh"

package dnc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  // One data word of U, h or nu
  typedef logic [`DNC_DATA_WIDTH-1:0] word_t;

  // Row or column index, also used for sizes
  typedef logic [`DNC_INDEX_WIDTH-1:0] index_t;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Matrix shape, U is size_y by size_l
  typedef struct packed {
    index_t size_y;
    index_t size_l;
  } dims_t;

  // Input stream from host to operand buffer
  typedef struct packed {
    logic  u_row_enable;  // first element of a new row
    logic  u_col_enable;  // one U element
    logic  h_enable;      // one h element
    word_t u_word;
    word_t h_word;
  } operand_write_t;

  // Operand pair presented to the MAC
  typedef struct packed {
    word_t u_word;
    word_t h_word;
  } operand_read_t;

  // Engine control FSM
  typedef enum logic [1:0] {idle, load, compute, emit} product_state_t;

endpackage

// File: rtl/ntm_operand_buffer.sv
`timescale 1ns/1ns
`include "dnc_settings.svh"

module ntm_operand_buffer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clear,
  input  dnc_pkg::dims_t          dims,
  input  dnc_pkg::operand_write_t write,
  input  dnc_pkg::index_t         row_index,
  input  dnc_pkg::index_t         col_index,
  output dnc_pkg::operand_read_t  operands,
  output logic                    loaded
);
  import dnc_pkg::*;

  // Address bits actually needed by the storage arrays
  localparam int ROW_BITS = $clog2(`DNC_MAX_Y);
  localparam int COL_BITS = $clog2(`DNC_MAX_L);
  localparam index_t ONE = index_t'(1);

  // Operand storage
  word_t u_mem [`DNC_MAX_Y][`DNC_MAX_L];
  word_t h_mem [`DNC_MAX_L];

  // Write side bookkeeping
  index_t wr_row;
  index_t wr_col;
  index_t h_count;
  logic   u_any;
  logic   u_done;

  index_t target_row;
  index_t target_col;
  logic   u_accept;
  logic   h_accept;

  //////////////////////////////////////////////////////////////////////
  // Write position
  //////////////////////////////////////////////////////////////////////

  // Row strobe moves to the next row
  // Not on the very first element though
  always_comb begin
    if (write.u_row_enable && u_any) begin
      target_row = wr_row + ONE;
      target_col = '0;
    end else begin
      target_row = wr_row;
      target_col = wr_col;
    end
  end

  // Drop anything past the matrix or past the last element
  assign u_accept = write.u_col_enable && !u_done &&
                    (target_row < dims.size_y) && (target_col < dims.size_l);
  assign h_accept = write.h_enable && (h_count < dims.size_l);

  // Counters, cleared on every accepted start
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_row  <= '0;
      wr_col  <= '0;
      h_count <= '0;
      u_any   <= 1'b0;
      u_done  <= 1'b0;
    end else begin
      if (u_accept) begin
        wr_row <= target_row;
        wr_col <= target_col + ONE;
        u_any  <= 1'b1;
        // Last element of the last row
        if ((target_row == dims.size_y - ONE) && (target_col == dims.size_l - ONE)) begin
          u_done <= 1'b1;
        end
      end
      if (h_accept) begin
        h_count <= h_count + ONE;
      end
    end
  end

  // Accepted words land at the current write positions
  always_ff @(posedge clk) begin
    if (u_accept) begin
      u_mem[target_row[ROW_BITS-1:0]][target_col[COL_BITS-1:0]] <= write.u_word;
    end
    if (h_accept) begin
      h_mem[h_count[COL_BITS-1:0]] <= write.h_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Plain mux on the engine's indices
  assign operands.u_word = u_mem[row_index[ROW_BITS-1:0]][col_index[COL_BITS-1:0]];
  assign operands.h_word = h_mem[col_index[COL_BITS-1:0]];

  // Both U and h complete
  assign loaded = u_done && (h_count == dims.size_l);

endmodule

// File: rtl/ntm_dot_product.sv
`timescale 1ns/1ns
`include "dnc_settings.svh"

module ntm_dot_product (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   accumulate,
  input  dnc_pkg::operand_read_t operands,
  output dnc_pkg::word_t         sum
);
  import dnc_pkg::*;

  // Full width of an unreduced product
  localparam int PRODUCT_WIDTH = 2 * `DNC_DATA_WIDTH;

  //////////////////////////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////////////////////////

  logic [PRODUCT_WIDTH-1:0] full_product;
  word_t                    product;
  word_t                    next_sum;
  word_t                    sum_q;

  // Unsigned multiply of the current operand pair
  assign full_product = operands.u_word * operands.h_word;

  // Keep the low word
  // This is the modulo 2^DNC_DATA_WIDTH reduction
  assign product = full_product[`DNC_DATA_WIDTH-1:0];

  // Add also wraps, so the running total stays modulo
  assign next_sum = sum_q + product;

  //////////////////////////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////////////////////////

  // Clear wins over accumulate
  // Engine never raises both in one cycle anyway
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      sum_q <= '0;
    end else if (accumulate) begin
      sum_q <= next_sum;
    end
  end

  // Registered running total
  // Final after the last accumulate cycle of a row
  assign sum = sum_q;

endmodule

// File: rtl/ntm_matrix_product.sv
`timescale 1ns/1ns
`include "dnc_settings.svh"

module ntm_matrix_product (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  output logic                    ready,
  input  dnc_pkg::dims_t          dims_in,
  input  dnc_pkg::operand_write_t write,
  output logic                    data_out_enable,
  output dnc_pkg::word_t          data_out
);
  import dnc_pkg::*;

  // Size limits in index width
  localparam index_t MAX_Y = index_t'(`DNC_MAX_Y);
  localparam index_t MAX_L = index_t'(`DNC_MAX_L);
  localparam index_t ONE   = index_t'(1);

  product_state_t state;
  dims_t          dims;
  index_t         row;
  index_t         col;
  logic           row_clear;

  logic           sizes_ok;
  logic           start_accept;
  logic           loaded;
  logic           clear;
  logic           accumulate;
  operand_read_t  operands;
  word_t          sum;

  //////////////////////////////////////////////////////////////////////
  // Start check
  //////////////////////////////////////////////////////////////////////

  // Zero or oversize shapes are ignored
  assign sizes_ok = (dims_in.size_y != '0) && (dims_in.size_y <= MAX_Y) &&
                    (dims_in.size_l != '0) && (dims_in.size_l <= MAX_L);

  // Start only counts while idle
  assign start_accept = start && (state == idle) && sizes_ok;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  // Per row: clear, size_l accumulates, one emit
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      dims      <= '0;
      row       <= '0;
      col       <= '0;
      row_clear <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (start_accept) begin
            dims  <= dims_in;
            row   <= '0;
            col   <= '0;
            state <= load;
          end
        end
        load: begin
          // Host paced, wait for both operands
          if (loaded) begin
            row_clear <= 1'b1;
            col       <= '0;
            state     <= compute;
          end
        end
        compute: begin
          if (row_clear) begin
            row_clear <= 1'b0;
          end else begin
            col <= col + ONE;
            if (col == dims.size_l - ONE) begin
              state <= emit;
            end
          end
        end
        emit: begin
          if (row == dims.size_y - ONE) begin
            state <= idle;
          end else begin
            // Next row starts with its own clear
            row       <= row + ONE;
            col       <= '0;
            row_clear <= 1'b1;
            state     <= compute;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // MAC strobes
  assign clear      = (state == compute) && row_clear;
  assign accumulate = (state == compute) && !row_clear;

  // Host side handshake and result
  assign ready           = (state == idle);
  assign data_out_enable = (state == emit);
  assign data_out        = sum;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  ntm_operand_buffer operand_buffer (
    .clk       (clk),
    .reset     (reset),
    .clear     (start_accept),
    .dims      (dims),
    .write     (write),
    .row_index (row),
    .col_index (col),
    .operands  (operands),
    .loaded    (loaded)
  );

  ntm_dot_product dot_product (
    .clk        (clk),
    .reset      (reset),
    .clear      (clear),
    .accumulate (accumulate),
    .operands   (operands),
    .sum        (sum)
  );

endmodule

// File: rtl/dnc_controller_output_vector.sv
`timescale 1ns/1ns

module dnc_controller_output_vector (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  output logic            ready,
  input  logic            u_in_y_enable,
  input  logic            u_in_l_enable,
  input  logic            h_in_enable,
  input  dnc_pkg::index_t size_y_in,
  input  dnc_pkg::index_t size_l_in,
  input  dnc_pkg::word_t  u_in,
  input  dnc_pkg::word_t  h_in,
  output logic            nu_enable_out,
  output dnc_pkg::word_t  nu_out
);
  import dnc_pkg::*;

  // nu(y) = sum over l of U(y,l)*h(l)
  // U is matrix A with size_y by size_l, h is a size_l vector

  dims_t          dims;
  operand_write_t write;

  // Shape of U, h length follows size_l
  assign dims.size_y = size_y_in;
  assign dims.size_l = size_l_in;

  // Input strobes and words
  assign write.u_row_enable = u_in_y_enable;
  assign write.u_col_enable = u_in_l_enable;
  assign write.h_enable     = h_in_enable;
  assign write.u_word       = u_in;
  assign write.h_word       = h_in;

  ntm_matrix_product matrix_product (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .ready           (ready),
    .dims_in         (dims),
    .write           (write),
    .data_out_enable (nu_enable_out),
    .data_out        (nu_out)
  );

endmodule

// File: verification/dnc_output_vector_properties.sv
`timescale 1ns/1ns
`include "dnc_settings.svh"

module dnc_output_vector_properties (
  input logic            clk,
  input logic            reset,
  input logic            start,
  input logic            ready,
  input dnc_pkg::index_t size_y_in,
  input dnc_pkg::index_t size_l_in,
  input logic            nu_enable_out
);
  import dnc_pkg::*;

  logic start_ok;

  // A start the engine must take
  assign start_ok = start && ready &&
                    (size_y_in != '0) && (size_y_in <= index_t'(`DNC_MAX_Y)) &&
                    (size_l_in != '0) && (size_l_in <= index_t'(`DNC_MAX_L));

  // Results only come while busy
  a_no_result_when_ready: assert property (@(posedge clk) disable iff (reset)
    !(nu_enable_out && ready)) else $error("result strobe while ready is high");

  // Idle right after reset
  a_ready_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> ready) else $error("ready low after reset release");

  // One cycle pulses
  a_single_pulse: assert property (@(posedge clk) disable iff (reset)
    nu_enable_out |=> !nu_enable_out) else $error("result strobe longer than one cycle");

  a_busy_after_start: assert property (@(posedge clk) disable iff (reset)
    start_ok |=> !ready) else $error("ready still high after an accepted start");

endmodule

bind dnc_controller_output_vector dnc_output_vector_properties control_checks (.*);

// File: verification/dnc_output_vector_tb.sv
`timescale 1ns/1ns
`include "dnc_settings.svh"

module dnc_output_vector_tb;
  import dnc_pkg::*;

  localparam int NUM_TESTS      = 9;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int STREAM_LIMIT   = 1000;
  localparam int REJECT_WATCH   = 20;
  localparam int W              = `DNC_DATA_WIDTH;

  typedef enum logic [1:0] {fill_fixed, fill_random, fill_ones} fill_mode_t;

  // One row of the test table
  typedef struct packed {
    index_t     size_y;
    index_t     size_l;
    fill_mode_t fill;
    logic       accept;
    logic       gaps;
  } test_entry_t;

  logic   clk;
  logic   reset;
  logic   start;
  logic   ready;
  logic   u_in_y_enable;
  logic   u_in_l_enable;
  logic   h_in_enable;
  index_t size_y_in;
  index_t size_l_in;
  word_t  u_in;
  word_t  h_in;
  logic   nu_enable_out;
  word_t  nu_out;

  test_entry_t tests [NUM_TESTS];
  string       test_names [NUM_TESTS];
  word_t       u_words [`DNC_MAX_Y][`DNC_MAX_L];
  word_t       h_words [`DNC_MAX_L];
  word_t       results [$];
  int          value_errors;
  int          other_errors;

  dnc_controller_output_vector dut (.*);

  // 8 ns clock
  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Table and operands
  //////////////////////////////////////////////////////////////////////

  task automatic set_entry(input int i, input string name, input int ny, input int nl,
                           input fill_mode_t fill, input logic accept, input logic gaps);
    test_names[i]       = name;
    tests[i].size_y = index_t'(ny);
    tests[i].size_l = index_t'(nl);
    tests[i].fill   = fill;
    tests[i].accept = accept;
    tests[i].gaps   = gaps;
  endtask

  task automatic fill_table();
    set_entry(0, "small_2x3", 2, 3, fill_fixed, 1'b1, 1'b0);
    set_entry(1, "max_8x8_gapped", 8, 8, fill_random, 1'b1, 1'b1);
    set_entry(2, "one_by_one", 1, 1, fill_fixed, 1'b1, 1'b0);
    set_entry(3, "one_by_eight", 1, 8, fill_random, 1'b1, 1'b1);
    set_entry(4, "all_ones_8x8", 8, 8, fill_ones, 1'b1, 1'b0);
    // Illegal shapes, start ignored
    set_entry(5, "zero_rows", 0, 3, fill_fixed, 1'b0, 1'b0);
    set_entry(6, "oversize_cols", 3, 9, fill_fixed, 1'b0, 1'b0);
    // Second run smaller than first, stale data would show up
    set_entry(7, "back_to_back_a", 6, 7, fill_random, 1'b1, 1'b1);
    set_entry(8, "back_to_back_b", 3, 4, fill_random, 1'b1, 1'b0);
  endtask

  task automatic make_operands(input fill_mode_t fill);
    logic [31:0] rnd;
    for (int r = 0; r < `DNC_MAX_Y; r++) begin
      for (int c = 0; c < `DNC_MAX_L; c++) begin
        rnd = $urandom;
        case (fill)
          fill_fixed:  u_words[r][c] = word_t'(16 * r + c + 1);
          fill_random: u_words[r][c] = rnd[W-1:0];
          default:     u_words[r][c] = '1;
        endcase
      end
    end
    for (int c = 0; c < `DNC_MAX_L; c++) begin
      rnd = $urandom;
      case (fill)
        fill_fixed:  h_words[c] = word_t'(2 * c + 3);
        fill_random: h_words[c] = rnd[W-1:0];
        default:     h_words[c] = '1;
      endcase
    end
  endtask

  // nu(row) as the sum of U(row,l)*h(l), wrapped to W bits
  function automatic word_t model_row(input int row, input int nl);
    logic [2*W-1:0] p;
    word_t          acc;
    acc = '0;
    for (int c = 0; c < nl; c++) begin
      p   = {{W{1'b0}}, u_words[row][c]} * {{W{1'b0}}, h_words[c]};
      acc = acc + p[W-1:0];
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Host side tasks, each entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic wait_for_ready(input string name);
    int cycles;
    cycles = 0;
    while (!ready && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    assert (ready) else begin
      other_errors++;
      $display("Timeout: ready stayed low before test %s", name);
    end
  endtask

  task automatic stream_operands(input string name, input int ny, input int nl,
                                 input logic gaps);
    int   u_pos;
    int   h_pos;
    int   cycles;
    logic send_u;
    logic send_h;
    u_pos  = 0;
    h_pos  = 0;
    cycles = 0;
    while ((u_pos < ny * nl || h_pos < nl) && cycles < STREAM_LIMIT) begin
      send_u = (u_pos < ny * nl);
      send_h = (h_pos < nl);
      if (gaps) begin
        // Interleaved streams with random idle cycles
        send_u = send_u && ($urandom % 3 != 0);
        send_h = send_h && ($urandom % 2 == 0);
      end else if (send_u) begin
        // All of U first, then h
        send_h = 1'b0;
      end
      u_in_l_enable = send_u;
      u_in_y_enable = send_u && (u_pos % nl == 0);
      u_in          = send_u ? u_words[u_pos / nl][u_pos % nl] : '0;
      h_in_enable   = send_h;
      h_in          = send_h ? h_words[h_pos] : '0;
      if (send_u) begin
        u_pos++;
      end
      if (send_h) begin
        h_pos++;
      end
      @(negedge clk);
      cycles++;
    end
    u_in_l_enable = 1'b0;
    u_in_y_enable = 1'b0;
    h_in_enable   = 1'b0;
    assert (u_pos == ny * nl && h_pos == nl) else begin
      other_errors++;
      $display("Test %s could not stream all operands in time", name);
    end
  endtask

  // Captures every result pulse until ready comes back
  task automatic collect_results(input string name);
    int cycles;
    cycles = 0;
    results.delete();
    while (!ready && cycles < TIMEOUT_CYCLES) begin
      if (nu_enable_out) begin
        results.push_back(nu_out);
      end
      @(negedge clk);
      cycles++;
    end
    assert (ready) else begin
      other_errors++;
      $display("Timeout: ready did not return high after test %s", name);
    end
  endtask

  task automatic run_test(input int t);
    string name;
    int    ny;
    int    nl;
    word_t expected;
    name = test_names[t];
    ny   = int'(tests[t].size_y);
    nl   = int'(tests[t].size_l);
    wait_for_ready(name);
    make_operands(tests[t].fill);
    // Start on the same edge that saw ready, so runs go back to back
    start     = 1'b1;
    size_y_in = tests[t].size_y;
    size_l_in = tests[t].size_l;
    @(negedge clk);
    start = 1'b0;
    if (tests[t].accept) begin
      assert (!ready) else begin
        value_errors++;
        $display("Fail %s: ready expected 0 actual 1", name);
      end
      stream_operands(name, ny, nl, tests[t].gaps);
      collect_results(name);
      assert (results.size() == ny) else begin
        value_errors++;
        $display("Fail %s: result count expected %0d actual %0d", name, ny, results.size());
      end
      for (int r = 0; r < ny && r < results.size(); r++) begin
        expected = model_row(r, nl);
        assert (results[r] == expected) else begin
          value_errors++;
          $display("Fail %s row %0d: expected %h actual %h", name, r, expected, results[r]);
        end
      end
    end else begin
      // Rejected shape, nothing may happen
      repeat (REJECT_WATCH) begin
        assert (ready && !nu_enable_out) else begin
          other_errors++;
          $display("Test %s saw a result or a busy engine after a rejected start", name);
        end
        @(negedge clk);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    start         = 1'b0;
    u_in_y_enable = 1'b0;
    u_in_l_enable = 1'b0;
    h_in_enable   = 1'b0;
    size_y_in     = '0;
    size_l_in     = '0;
    u_in          = '0;
    h_in          = '0;
    value_errors  = 0;
    other_errors  = 0;
    void'($urandom(5));
    fill_table();
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Errors: %0d value mismatches, %0d timeouts or protocol errors",
             value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+rtl
rtl/dnc_pkg.sv
rtl/ntm_operand_buffer.sv
rtl/ntm_dot_product.sv
rtl/ntm_matrix_product.sv
rtl/dnc_controller_output_vector.sv
verification/dnc_output_vector_properties.sv
verification/dnc_output_vector_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the output vector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module dnc_output_vector_tb \
  --Mdir obj_dir -o sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim > sim.log 2>&1

grep -q "^All checks passed$" sim.log \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }
